// ==== Bender.yml ====
package:
  name: minirv_exec

sources:
  - include_dirs:
      - hw
    files:
      - hw/minirv_isa_pkg.sv
      - hw/minirv_bus_pkg.sv
      - hw/regfile_if.sv
      - hw/regfile_1w2r.sv
      - hw/regfile_arbiter.sv
      - hw/alu_exec.sv
      - hw/axil_host_port.sv
      - hw/minirv_exec_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/tb_minirv_exec.sv

// ==== hw/alu_exec.sv ====
//--------------------------------------------------------------------------
// Execute unit, runs one R-type or I-type ALU instruction at a time
// Operand read, compute with write back, then done or error pulse
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "minirv_cfg.svh"

module alu_exec (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_valid,
	input  minirv_isa_pkg::instr_u cmd_instr,
	output logic cmd_ready,
	output logic cmd_done,
	output logic cmd_err,
	regfile_if.requester rf
);

	typedef enum logic [1:0] {S_IDLE, S_READ, S_EXEC, S_DONE} state_t;

	state_t state;
	logic err_q;
	minirv_isa_pkg::instr_u instr_q;
	minirv_isa_pkg::instr_u dec;
	minirv_isa_pkg::alu_op_e alu_op;
	logic is_op;
	logic is_imm;
	logic [6:0] hi7;
	logic f7_zero;
	logic f7_alt;
	logic funct_ok;
	logic regs_ok;
	logic legal;
	logic [`MINIRV_XLEN-1:0] imm_sext;
	logic [`MINIRV_XLEN-1:0] op_a;
	logic [`MINIRV_XLEN-1:0] op_b;
	logic [4:0] shamt;
	logic [`MINIRV_XLEN-1:0] result;

	// Legality is checked on the incoming word, the rest on the held one
	assign dec = (state == S_IDLE) ? cmd_instr : instr_q;

	assign is_op = dec.r.opcode == minirv_isa_pkg::OPC_OP;
	assign is_imm = dec.i.opcode == minirv_isa_pkg::OPC_OP_IMM;
	// Top seven bits, funct7 or the high immediate
	assign hi7 = dec.r.funct7;
	assign f7_zero = hi7 == 7'b0000000;
	assign f7_alt = hi7 == 7'b0100000;

	always_comb begin
		alu_op = minirv_isa_pkg::ALU_ADD;
		funct_ok = is_imm || f7_zero;
		case (dec.r.funct3)
			minirv_isa_pkg::F3_ADD_SUB: begin
				// No subi, immediate bits are just immediate
				alu_op = (is_op && f7_alt) ? minirv_isa_pkg::ALU_SUB : minirv_isa_pkg::ALU_ADD;
				funct_ok = is_imm || f7_zero || f7_alt;
			end
			minirv_isa_pkg::F3_SLL: begin
				alu_op = minirv_isa_pkg::ALU_SLL;
				funct_ok = f7_zero;
			end
			minirv_isa_pkg::F3_SLT: alu_op = minirv_isa_pkg::ALU_SLT;
			minirv_isa_pkg::F3_SLTU: alu_op = minirv_isa_pkg::ALU_SLTU;
			minirv_isa_pkg::F3_XOR: alu_op = minirv_isa_pkg::ALU_XOR;
			minirv_isa_pkg::F3_SRL_SRA: begin
				alu_op = f7_alt ? minirv_isa_pkg::ALU_SRA : minirv_isa_pkg::ALU_SRL;
				funct_ok = f7_zero || f7_alt;
			end
			minirv_isa_pkg::F3_OR: alu_op = minirv_isa_pkg::ALU_OR;
			default: alu_op = minirv_isa_pkg::ALU_AND;
		endcase
	end

	// RV32E, only x0..x15 exist
	assign regs_ok = !dec.r.rd[4] && !dec.r.rs1[4] && (is_imm || !dec.r.rs2[4]);
	assign legal = (is_op || is_imm) && funct_ok && regs_ok;

	assign imm_sext = {{(`MINIRV_XLEN-12){dec.i.imm[11]}}, dec.i.imm};
	assign op_a = rf.rdata1;
	assign op_b = is_imm ? imm_sext : rf.rdata2;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			minirv_isa_pkg::ALU_ADD: result = op_a + op_b;
			minirv_isa_pkg::ALU_SUB: result = op_a - op_b;
			minirv_isa_pkg::ALU_AND: result = op_a & op_b;
			minirv_isa_pkg::ALU_OR: result = op_a | op_b;
			minirv_isa_pkg::ALU_XOR: result = op_a ^ op_b;
			minirv_isa_pkg::ALU_SLL: result = op_a << shamt;
			minirv_isa_pkg::ALU_SRL: result = op_a >> shamt;
			minirv_isa_pkg::ALU_SRA: result = $signed(op_a) >>> shamt;
			minirv_isa_pkg::ALU_SLT: begin
				result = {{(`MINIRV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			default: result = {{(`MINIRV_XLEN-1){1'b0}}, op_a < op_b};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			err_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (cmd_valid) begin
					// Illegal goes straight to the error pulse
					err_q <= !legal;
					state <= legal ? S_READ : S_DONE;
				end
				S_READ: if (rf.gnt) state <= S_EXEC;
				S_EXEC: if (rf.gnt) state <= S_DONE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready) begin
			instr_q <= cmd_instr;
		end
	end

	assign cmd_ready = state == S_IDLE;
	assign cmd_done = (state == S_DONE) && !err_q;
	assign cmd_err = (state == S_DONE) && err_q;

	// Operands in READ, result written in EXEC
	assign rf.req = (state == S_READ) || (state == S_EXEC);
	assign rf.we = state == S_EXEC;
	assign rf.raddr1 = instr_q.r.rs1[`MINIRV_RADDR_W-1:0];
	assign rf.raddr2 = instr_q.r.rs2[`MINIRV_RADDR_W-1:0];
	assign rf.waddr = instr_q.r.rd[`MINIRV_RADDR_W-1:0];
	assign rf.wdata = result;

endmodule

// ==== hw/axil_host_port.sv ====
//--------------------------------------------------------------------------
// AXI4-Lite host port, maps addresses to register accesses
// or instruction submissions, one transaction in flight
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "minirv_cfg.svh"

module axil_host_port (
	input  logic clk,
	input  logic rst_n,
	input  logic [`MINIRV_AXIL_AW-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`MINIRV_XLEN-1:0] wdata,
	// Registers are always written as a whole word
	input  logic [`MINIRV_XLEN/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`MINIRV_AXIL_AW-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`MINIRV_XLEN-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic cmd_valid,
	output minirv_isa_pkg::instr_u cmd_instr,
	input  logic cmd_ready,
	input  logic cmd_done,
	input  logic cmd_err,
	regfile_if.requester rf
);

	typedef enum logic [2:0] {
		H_IDLE, H_WR_REG, H_WR_CMD, H_WR_WAIT,
		H_RD_REG, H_RD_DATA, H_BRESP, H_RRESP
	} state_t;

	state_t state;
	minirv_bus_pkg::host_region_e aw_region;
	minirv_bus_pkg::host_region_e ar_region;
	minirv_bus_pkg::axil_resp_e bresp_q;
	minirv_bus_pkg::axil_resp_e rresp_q;
	logic wr_take;
	logic rd_take;
	logic [`MINIRV_RADDR_W-1:0] reg_idx;
	logic [`MINIRV_XLEN-1:0] wdata_q;
	logic [`MINIRV_XLEN-1:0] rdata_q;

	function automatic minirv_bus_pkg::host_region_e decode_region(
		input logic [`MINIRV_AXIL_AW-1:0] addr
	);
		if (addr == `MINIRV_CMD_ADDR) begin
			return minirv_bus_pkg::REGION_CMD;
		end
		// Word-aligned and within x0..x15
		if (addr[1:0] == 2'b00 && addr[`MINIRV_AXIL_AW-1:2] < `MINIRV_N_REGS) begin
			return minirv_bus_pkg::REGION_REG;
		end
		return minirv_bus_pkg::REGION_NONE;
	endfunction

	assign aw_region = decode_region(awaddr);
	assign ar_region = decode_region(araddr);

	// AW and W only together, write wins a tie with AR
	assign wr_take = (state == H_IDLE) && awvalid && wvalid;
	assign rd_take = (state == H_IDLE) && arvalid && !(awvalid && wvalid);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= H_IDLE;
			bresp_q <= minirv_bus_pkg::RESP_OKAY;
			rresp_q <= minirv_bus_pkg::RESP_OKAY;
		end else begin
			case (state)
				H_IDLE: begin
					if (wr_take) begin
						bresp_q <= minirv_bus_pkg::RESP_OKAY;
						case (aw_region)
							minirv_bus_pkg::REGION_REG: state <= H_WR_REG;
							minirv_bus_pkg::REGION_CMD: state <= H_WR_CMD;
							default: begin
								bresp_q <= minirv_bus_pkg::RESP_SLVERR;
								state <= H_BRESP;
							end
						endcase
					end else if (rd_take) begin
						// The command address is write-only
						if (ar_region == minirv_bus_pkg::REGION_REG) begin
							rresp_q <= minirv_bus_pkg::RESP_OKAY;
							state <= H_RD_REG;
						end else begin
							rresp_q <= minirv_bus_pkg::RESP_SLVERR;
							state <= H_RRESP;
						end
					end
				end
				H_WR_REG: if (rf.gnt) state <= H_BRESP;
				H_WR_CMD: if (cmd_ready) state <= H_WR_WAIT;
				// Response held until the instruction retires
				H_WR_WAIT: begin
					if (cmd_done || cmd_err) begin
						bresp_q <= cmd_err ? minirv_bus_pkg::RESP_SLVERR
								: minirv_bus_pkg::RESP_OKAY;
						state <= H_BRESP;
					end
				end
				H_RD_REG: if (rf.gnt) state <= H_RD_DATA;
				H_RD_DATA: state <= H_RRESP;
				H_BRESP: if (bready) state <= H_IDLE;
				default: if (rready) state <= H_IDLE;
			endcase
		end
	end

	// Address, write data and read data captures
	always_ff @(posedge clk) begin
		if (wr_take) begin
			wdata_q <= wdata;
			reg_idx <= awaddr[2 +: `MINIRV_RADDR_W];
		end else if (rd_take) begin
			reg_idx <= araddr[2 +: `MINIRV_RADDR_W];
		end
		if (state == H_RD_DATA) begin
			rdata_q <= rf.rdata1;
		end else if (rd_take) begin
			rdata_q <= '0;
		end
	end

	assign awready = wr_take;
	assign wready = wr_take;
	assign arready = rd_take;
	assign bvalid = state == H_BRESP;
	assign bresp = bresp_q;
	assign rvalid = state == H_RRESP;
	assign rresp = rresp_q;
	assign rdata = rdata_q;

	assign cmd_valid = state == H_WR_CMD;
	assign cmd_instr = wdata_q;

	// Single register per access, both read ports on the same index
	assign rf.req = (state == H_WR_REG) || (state == H_RD_REG);
	assign rf.we = state == H_WR_REG;
	assign rf.waddr = reg_idx;
	assign rf.wdata = wdata_q;
	assign rf.raddr1 = reg_idx;
	assign rf.raddr2 = reg_idx;

endmodule

// ==== hw/minirv_bus_pkg.sv ====
//--------------------------------------------------------------------------
// Host bus definitions, AXI4-Lite responses and address map regions
//--------------------------------------------------------------------------
package minirv_bus_pkg;

	// Only the two responses this slave ever returns
	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// Result of decoding one host address
	typedef enum logic [1:0] {
		REGION_REG,
		REGION_CMD,
		REGION_NONE
	} host_region_e;

endpackage

// ==== hw/minirv_cfg.svh ====
//--------------------------------------------------------------------------
// Minirv execute subsystem configuration
// Register file geometry and host address map constants
//--------------------------------------------------------------------------
`ifndef MINIRV_CFG_SVH
`define MINIRV_CFG_SVH

// Architectural registers, x0 to x15
`define MINIRV_N_REGS 16
`define MINIRV_XLEN 32
// Index width for the 16 registers
`define MINIRV_RADDR_W 4

// Host side, byte address width
`define MINIRV_AXIL_AW 12
// Writing here submits one instruction word
`define MINIRV_CMD_ADDR 12'h100

`endif

// ==== hw/minirv_exec_top.sv ====
//--------------------------------------------------------------------------
// Minirv execute subsystem top, AXI4-Lite host port, execute unit,
// arbiter and shared register file
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "minirv_cfg.svh"

module minirv_exec_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [`MINIRV_AXIL_AW-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`MINIRV_XLEN-1:0] wdata,
	input  logic [`MINIRV_XLEN/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`MINIRV_AXIL_AW-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`MINIRV_XLEN-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready
);

	// Instruction handoff
	logic cmd_valid;
	logic cmd_ready;
	logic cmd_done;
	logic cmd_err;
	minirv_isa_pkg::instr_u cmd_instr;

	// Arbiter to register file
	logic [`MINIRV_RADDR_W-1:0] rf_raddr1;
	logic [`MINIRV_RADDR_W-1:0] rf_raddr2;
	logic rf_we;
	logic [`MINIRV_RADDR_W-1:0] rf_waddr;
	logic [`MINIRV_XLEN-1:0] rf_wdata;
	logic [`MINIRV_XLEN-1:0] rf_rdata1;
	logic [`MINIRV_XLEN-1:0] rf_rdata2;

	regfile_if exec_rf ();
	regfile_if host_rf ();

	axil_host_port u_host (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.cmd_valid(cmd_valid), .cmd_instr(cmd_instr), .cmd_ready(cmd_ready),
		.cmd_done(cmd_done), .cmd_err(cmd_err),
		.rf(host_rf)
	);

	alu_exec u_exec (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_instr(cmd_instr), .cmd_ready(cmd_ready),
		.cmd_done(cmd_done), .cmd_err(cmd_err),
		.rf(exec_rf)
	);

	regfile_arbiter u_arb (
		.clk(clk), .rst_n(rst_n),
		.exec_port(exec_rf), .host_port(host_rf),
		.raddr1(rf_raddr1), .raddr2(rf_raddr2),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2)
	);

	regfile_1w2r u_rf (
		.clk(clk), .rst_n(rst_n),
		.raddr1(rf_raddr1), .raddr2(rf_raddr2),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2)
	);

endmodule

// ==== hw/minirv_isa_pkg.sv ====
//--------------------------------------------------------------------------
// RV32E integer subset, instruction layouts, opcodes and ALU operations
//--------------------------------------------------------------------------
package minirv_isa_pkg;

	// Register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	// Register-immediate layout, imm[11:5] overlays funct7
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_i_t;

	// One instruction word, seen through either layout
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
	} alu_op_e;

endpackage

// ==== hw/regfile_1w2r.sv ====
//--------------------------------------------------------------------------
// Register file, 16 x 32, one write port and two registered read ports
// x0 is never written so it always reads zero
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "minirv_cfg.svh"

module regfile_1w2r (
	input  logic clk,
	input  logic rst_n,
	input  logic [`MINIRV_RADDR_W-1:0] raddr1,
	input  logic [`MINIRV_RADDR_W-1:0] raddr2,
	input  logic we,
	input  logic [`MINIRV_RADDR_W-1:0] waddr,
	input  logic [`MINIRV_XLEN-1:0] wdata,
	output logic [`MINIRV_XLEN-1:0] rdata1,
	output logic [`MINIRV_XLEN-1:0] rdata2
);

	logic [`MINIRV_XLEN-1:0] mem [`MINIRV_N_REGS];

	// Flop array, all registers start at zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MINIRV_N_REGS; i++) begin
				mem[i] <= '0;
			end
			rdata1 <= '0;
			rdata2 <= '0;
		end else begin
			// Index 0 is hardwired
			if (we && waddr != '0) begin
				mem[waddr] <= wdata;
			end
			// Reads follow the addresses every cycle, old data on collision
			rdata1 <= mem[raddr1];
			rdata2 <= mem[raddr2];
		end
	end

endmodule

// ==== hw/regfile_arbiter.sv ====
//--------------------------------------------------------------------------
// Fixed-priority register file arbiter, execute unit over host port
// Read data goes back only to the requester granted last
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "minirv_cfg.svh"

module regfile_arbiter (
	input  logic clk,
	input  logic rst_n,
	regfile_if.arbiter exec_port,
	regfile_if.arbiter host_port,
	output logic [`MINIRV_RADDR_W-1:0] raddr1,
	output logic [`MINIRV_RADDR_W-1:0] raddr2,
	output logic we,
	output logic [`MINIRV_RADDR_W-1:0] waddr,
	output logic [`MINIRV_XLEN-1:0] wdata,
	input  logic [`MINIRV_XLEN-1:0] rdata1,
	input  logic [`MINIRV_XLEN-1:0] rdata2
);

	logic exec_owner;
	logic any_gnt;
	// Read addresses of the last grant, replayed while idle
	logic [`MINIRV_RADDR_W-1:0] raddr1_q;
	logic [`MINIRV_RADDR_W-1:0] raddr2_q;

	// Execute unit always wins, host waits
	assign exec_port.gnt = exec_port.req;
	assign host_port.gnt = host_port.req && !exec_port.req;
	assign any_gnt = exec_port.req || host_port.req;

	always_comb begin
		if (exec_port.req) begin
			raddr1 = exec_port.raddr1;
			raddr2 = exec_port.raddr2;
			we = exec_port.we;
			waddr = exec_port.waddr;
			wdata = exec_port.wdata;
		end else if (host_port.req) begin
			raddr1 = host_port.raddr1;
			raddr2 = host_port.raddr2;
			we = host_port.we;
			waddr = host_port.waddr;
			wdata = host_port.wdata;
		end else begin
			// Keeps read data steady until the next grant
			raddr1 = raddr1_q;
			raddr2 = raddr2_q;
			we = 1'b0;
			waddr = host_port.waddr;
			wdata = host_port.wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exec_owner <= 1'b0;
			raddr1_q <= '0;
			raddr2_q <= '0;
		end else if (any_gnt) begin
			exec_owner <= exec_port.req;
			raddr1_q <= raddr1;
			raddr2_q <= raddr2;
		end
	end

	// Return path steered by last owner
	assign exec_port.rdata1 = exec_owner ? rdata1 : '0;
	assign exec_port.rdata2 = exec_owner ? rdata2 : '0;
	assign host_port.rdata1 = exec_owner ? '0 : rdata1;
	assign host_port.rdata2 = exec_owner ? '0 : rdata2;

endmodule

// ==== hw/regfile_if.sv ====
//--------------------------------------------------------------------------
// One requester's access path to the shared register file
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "minirv_cfg.svh"

interface regfile_if;

	// Request, held until granted
	logic req;
	logic gnt;

	logic [`MINIRV_RADDR_W-1:0] raddr1;
	logic [`MINIRV_RADDR_W-1:0] raddr2;

	// Write lands on the edge that closes the granted cycle
	logic we;
	logic [`MINIRV_RADDR_W-1:0] waddr;
	logic [`MINIRV_XLEN-1:0] wdata;

	// Valid the cycle after the grant
	logic [`MINIRV_XLEN-1:0] rdata1;
	logic [`MINIRV_XLEN-1:0] rdata2;

	modport requester (
		output req, raddr1, raddr2, we, waddr, wdata,
		input gnt, rdata1, rdata2
	);

	modport arbiter (
		input req, raddr1, raddr2, we, waddr, wdata,
		output gnt, rdata1, rdata2
	);

endinterface

// ==== minirv_exec.f ====
+incdir+hw
hw/minirv_isa_pkg.sv
hw/minirv_bus_pkg.sv
hw/regfile_if.sv
hw/regfile_1w2r.sv
hw/regfile_arbiter.sv
hw/alu_exec.sv
hw/axil_host_port.sv
hw/minirv_exec_top.sv
sim/tb_minirv_exec.sv

// ==== sim/tb_minirv_exec.sv ====
//--------------------------------------------------------------------------
// Testbench for the minirv execute subsystem, drives the AXI4-Lite host
// side and checks registers and instructions against a reference model
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "minirv_cfg.svh"

module tb_minirv_exec;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	// Transactions over all tests, sets the watchdog budget
	localparam int N_TXNS = 16 + 32 + 60 * 4 + 22 + 4 + 22;

	logic clk;
	logic rst_n;
	logic [11:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [11:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// Architectural state as the host should see it
	logic [31:0] model [16];
	logic [31:0] lcg_state;
	int value_errs;
	int proto_errs;

	minirv_exec_top DUT (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Outputs stay quiet while reset is held
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !(awready || wready || arready || bvalid || rvalid))
	else begin
		proto_errs++;
		$display("Protocol error at %0t: handshake output high during reset", $time);
	end

	// AW and W are taken in the same cycle
	a_aw_w_together: assert property (@(posedge clk) disable iff (!rst_n)
		awready == wready)
	else begin
		proto_errs++;
		$display("Protocol error at %0t: awready and wready differ", $time);
	end

	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid && !bready) |=> (bvalid && $stable(bresp)))
	else begin
		proto_errs++;
		$display("Protocol error at %0t: write response dropped or changed", $time);
	end

	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && !rready) |=> (rvalid && $stable(rresp) && $stable(rdata)))
	else begin
		proto_errs++;
		$display("Protocol error at %0t: read response dropped or changed", $time);
	end

	// One transaction in flight, so one response at most
	a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
		!(bvalid && rvalid) && !((bvalid || rvalid) && (awready || arready)))
	else begin
		proto_errs++;
		$display("Protocol error at %0t: second transaction while response pending", $time);
	end

	a_resp_ends: assert property (@(posedge clk) disable iff (!rst_n)
		((bvalid && bready) || (rvalid && rready)) |=> !(bvalid || rvalid))
	else begin
		proto_errs++;
		$display("Protocol error at %0t: response repeated after acceptance", $time);
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper halves only, the low LCG bits repeat quickly
	function automatic logic [31:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:16]) % n;
	endfunction

	// Ops 0..9 are R-type, 10..18 I-type, shifts at 16..18
	function automatic logic [31:0] encode_instr(input int op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = 7'h00;
		f3 = 3'd0;
		case (op)
			1: f7 = 7'h20;
			2, 16: f3 = 3'd1;
			3, 11: f3 = 3'd2;
			4, 12: f3 = 3'd3;
			5, 13: f3 = 3'd4;
			6, 17: f3 = 3'd5;
			7, 18: begin
				f3 = 3'd5;
				f7 = 7'h20;
			end
			8, 14: f3 = 3'd6;
			9, 15: f3 = 3'd7;
			default: f3 = 3'd0;
		endcase
		if (op < 10) begin
			return {f7, rs2, rs1, f3, rd, 7'b0110011};
		end
		if (op >= 16) begin
			return {f7, imm[4:0], rs1, f3, rd, 7'b0010011};
		end
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	// RV32I integer semantics, b is rs2 or the sign-extended immediate
	function automatic logic [31:0] expected_result(input int op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			0, 10: return a + b;
			1: return a - b;
			2, 16: return a << b[4:0];
			3, 11: return {31'b0, $signed(a) < $signed(b)};
			4, 12: return {31'b0, a < b};
			5, 13: return a ^ b;
			6, 17: return a >> b[4:0];
			7, 18: return $signed(a) >>> b[4:0];
			8, 14: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			value_errs++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// AW and W together, then bready after a random delay
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		delay = rand_below(4);
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'(rand_below(16));
		wvalid <= 1'b1;
		do begin
			@(negedge clk);
		end while (!awready);
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do begin
			@(negedge clk);
		end while (!bvalid);
		resp = bresp;
		repeat (delay) @(negedge clk);
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		delay = rand_below(4);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do begin
			@(negedge clk);
		end while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do begin
			@(negedge clk);
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		repeat (delay) @(negedge clk);
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// AW, W and AR offered in one cycle, the write goes first
	// and the read waits until the write response is accepted
	task automatic write_read_race(input int idx, input logic [31:0] val);
		logic [1:0] wr_resp;
		logic [1:0] rd_resp;
		logic [31:0] data;
		@(posedge clk);
		awaddr <= 12'(idx * 4);
		awvalid <= 1'b1;
		wdata <= val;
		wstrb <= 4'hF;
		wvalid <= 1'b1;
		araddr <= 12'(idx * 4);
		arvalid <= 1'b1;
		do begin
			@(negedge clk);
		end while (!awready);
		assert (!arready) else begin
			proto_errs++;
			$display("Protocol error at %0t: read taken before a same-cycle write", $time);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do begin
			@(negedge clk);
		end while (!bvalid);
		wr_resp = bresp;
		// Read stays offered while the write response is held
		repeat (3) @(negedge clk);
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
		do begin
			@(negedge clk);
		end while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do begin
			@(negedge clk);
		end while (!rvalid);
		data = rdata;
		rd_resp = rresp;
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
		check_word("same-cycle write bresp", wr_resp, minirv_bus_pkg::RESP_OKAY);
		if (idx != 0) begin
			model[idx] = val;
		end
		check_word($sformatf("x%0d rresp after same-cycle write", idx), rd_resp,
				minirv_bus_pkg::RESP_OKAY);
		check_word($sformatf("x%0d after same-cycle write", idx), data, model[idx]);
	endtask

	task automatic reg_write(input int idx, input logic [31:0] val);
		logic [1:0] resp;
		axi_write(12'(idx * 4), val, resp);
		check_word("register write bresp", resp, minirv_bus_pkg::RESP_OKAY);
		// x0 ignores writes
		if (idx != 0) begin
			model[idx] = val;
		end
	endtask

	task automatic reg_check(input int idx);
		logic [1:0] resp;
		logic [31:0] data;
		axi_read(12'(idx * 4), data, resp);
		check_word($sformatf("x%0d rresp", idx), resp, minirv_bus_pkg::RESP_OKAY);
		check_word($sformatf("x%0d value", idx), data, model[idx]);
	endtask

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + 200 * N_TXNS));
		$display("Timeout: the run did not finish within its cycle budget");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int op;
		int rd;
		int rs1;
		int rs2;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] b;
		logic [31:0] exp;
		logic [11:0] imm;
		logic [1:0] resp;
		logic [31:0] data;
		logic [31:0] bad [6];
		lcg_state = 32'd76857;
		value_errs = 0;
		proto_errs = 0;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int i = 0; i < 16; i++) begin
			model[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// Everything reads zero after reset
		for (int i = 0; i < 16; i++) begin
			reg_check(i);
		end

		// Direct host writes, x0 keeps zero
		for (int i = 1; i < 16; i++) begin
			reg_write(i, rand_word());
			reg_check(i);
		end
		reg_write(0, rand_word());
		reg_check(0);

		// All nineteen ops, each at least three times
		for (int i = 0; i < 60; i++) begin
			op = i % 19;
			rd = (i % 10 == 0) ? 0 : rand_below(16);
			rs1 = rand_below(16);
			rs2 = rand_below(16);
			v1 = rand_word();
			v2 = rand_word();
			// Mixed signs for slt against sltu
			if (i % 2 == 1) begin
				v2[31] = ~v1[31];
			end
			// Negative operand so sign fill shows
			if (op == 7 || op == 18) begin
				v1[31] = 1'b1;
			end
			imm = 12'(rand_below(4096));
			reg_write(rs1, v1);
			reg_write(rs2, v2);
			b = (op < 10) ? model[rs2] : {{20{imm[11]}}, imm};
			exp = expected_result(op, model[rs1], b);
			axi_write(`MINIRV_CMD_ADDR, encode_instr(op, 5'(rd), 5'(rs1), 5'(rs2), imm), resp);
			check_word($sformatf("op %0d bresp", op), resp, minirv_bus_pkg::RESP_OKAY);
			if (rd != 0) begin
				model[rd] = exp;
			end
			reg_check(rd);
		end

		// Load opcode, mul funct7, slli with funct7 20, then out-of-range indices
		bad[0] = {12'h005, 5'd1, 3'd0, 5'd2, 7'b0000011};
		bad[1] = {7'h01, 5'd2, 5'd3, 3'd0, 5'd4, 7'b0110011};
		bad[2] = {7'h20, 5'd3, 5'd1, 3'd1, 5'd5, 7'b0010011};
		bad[3] = {7'h00, 5'd2, 5'd3, 3'd0, 5'd17, 7'b0110011};
		bad[4] = {12'h001, 5'd20, 3'd0, 5'd6, 7'b0010011};
		bad[5] = {7'h00, 5'd31, 5'd1, 3'd7, 5'd7, 7'b0110011};
		for (int i = 0; i < 6; i++) begin
			axi_write(`MINIRV_CMD_ADDR, bad[i], resp);
			check_word($sformatf("illegal %0d bresp", i), resp,
					minirv_bus_pkg::RESP_SLVERR);
		end
		for (int i = 0; i < 16; i++) begin
			reg_check(i);
		end

		// Write and read arriving together on one register
		rd = 1 + rand_below(15);
		v1 = rand_word();
		write_read_race(rd, v1);
		v1 = rand_word();
		write_read_race(0, v1);

		// Unmapped writes and reads, command address is write-only
		axi_write(12'h040, rand_word(), resp);
		check_word("write 0x040 bresp", resp, minirv_bus_pkg::RESP_SLVERR);
		axi_write(12'h002, rand_word(), resp);
		check_word("write 0x002 bresp", resp, minirv_bus_pkg::RESP_SLVERR);
		axi_write(12'h3FC, rand_word(), resp);
		check_word("write 0x3fc bresp", resp, minirv_bus_pkg::RESP_SLVERR);
		axi_read(12'h040, data, resp);
		check_word("read 0x040 rresp", resp, minirv_bus_pkg::RESP_SLVERR);
		check_word("read 0x040 data", data, '0);
		axi_read(12'h002, data, resp);
		check_word("read 0x002 rresp", resp, minirv_bus_pkg::RESP_SLVERR);
		check_word("read 0x002 data", data, '0);
		axi_read(`MINIRV_CMD_ADDR, data, resp);
		check_word("read command rresp", resp, minirv_bus_pkg::RESP_SLVERR);
		check_word("read command data", data, '0);
		for (int i = 0; i < 16; i++) begin
			reg_check(i);
		end

		repeat (4) @(posedge clk);
		$display("Errors: %0d value mismatches, %0d protocol violations",
				value_errs, proto_errs);
		if (value_errs + proto_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
